// ==== source/cfgPkg.sv ====
// Dispatch shared definitions
`default_nettype none

package cfgPkg;

    // ========================================
    // Sizes
    // ========================================
    localparam int numEngines  = 3;
    localparam int wordWidth   = 32;
    localparam int opcodeWidth = 8;

    // Bit 8 of the first word marks an urgent instruction
    localparam int urgentBit = 8;

    // Instruction lengths in words
    localparam int fpsWords = 1;
    localparam int syaWords = 2;
    localparam int polWords = 4;

    // ========================================
    // Types
    // ========================================
    typedef logic [wordWidth-1:0]   isaWord_t;
    typedef logic [opcodeWidth-1:0] opcode_t;
    typedef logic [1:0]             engineSel_t;

    // Decoder states
    typedef enum logic [1:0] {
        stIdle,
        stCollect,
        stDiscard
    } decState_t;

endpackage

`default_nettype wire

// ==== source/isaDecoder.sv ====
// Instruction opcode decoder
`timescale 1ns/1ps
`default_nettype none

module isaDecoder
    import cfgPkg::*;
(
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire isaWord_t          inDat,
    input  wire                    inVld,
    input  wire                    inLast,
    output logic                   inRdy,
    output logic [numEngines-1:0]  wordVld,
    input  wire  [numEngines-1:0]  wordRdy,
    input  wire  [numEngines-1:0]  isaDone
);

    decState_t  state;
    decState_t  nextState;
    engineSel_t engSel;
    opcode_t    opcode;

    // Opcode sits in the low byte of the first word
    assign opcode = inDat[opcodeWidth-1:0];

    // ========================================
    // State machine
    // ========================================
    always_comb begin
        nextState = state;
        case (state)
            stIdle: begin
                if (inVld) begin
                    if (opcode < opcode_t'(numEngines)) begin
                        nextState = stCollect;
                    end else begin
                        nextState = stDiscard;
                    end
                end
            end
            // Done once the collector hands its instruction to the queue
            stCollect: begin
                if (isaDone[engSel]) begin
                    nextState = stIdle;
                end
            end
            stDiscard: begin
                if (inVld && inLast) begin
                    nextState = stIdle;
                end
            end
            default: nextState = stIdle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= stIdle;
            engSel <= '0;
        end else begin
            state <= nextState;
            if (state == stIdle && inVld) begin
                engSel <= engineSel_t'(opcode);
            end
        end
    end

    // ========================================
    // Word steering
    // ========================================
    always_comb begin
        wordVld = '0;
        inRdy   = 1'b0;
        case (state)
            stCollect: begin
                wordVld[engSel] = inVld;
                inRdy           = wordRdy[engSel];
            end
            // Unknown opcode, swallow everything up to inLast
            stDiscard: inRdy = 1'b1;
            default:   inRdy = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/isaCollector.sv ====
// Instruction word collector
`timescale 1ns/1ps
`default_nettype none

module isaCollector
    import cfgPkg::*;
#(
    parameter int wordsPerIsa = 1
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire isaWord_t                    wordDat,
    input  wire                              wordVld,
    output logic                             wordRdy,
    output logic [wordsPerIsa*wordWidth-1:0] isaDat,
    output logic                             isaVld,
    input  wire                              isaRdy
);

    localparam int cntWidth = $clog2(wordsPerIsa + 1);

    typedef logic [cntWidth-1:0] wordCnt_t;

    wordCnt_t wordCnt;
    logic     wordAcc;
    logic [wordsPerIsa-1:0][wordWidth-1:0] slots;

    // Full once every slot is filled
    assign isaVld  = (wordCnt == wordCnt_t'(wordsPerIsa));
    assign wordRdy = !isaVld;
    assign wordAcc = wordVld && wordRdy;
    assign isaDat  = slots;

    // ========================================
    // Word counter
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wordCnt <= '0;
        end else if (isaVld && isaRdy) begin
            wordCnt <= '0;
        end else if (wordAcc) begin
            wordCnt <= wordCnt + 1'b1;
        end
    end

    // Word 0 lands in the low bits
    always_ff @(posedge clk) begin
        for (int i = 0; i < wordsPerIsa; i++) begin
            if (wordAcc && wordCnt == wordCnt_t'(i)) begin
                slots[i] <= wordDat;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/isaQueue.sv ====
// First-word-fall-through queue
`timescale 1ns/1ps
`default_nettype none

module isaQueue #(
    parameter int dataWidth      = 32,
    parameter int queueAddrWidth = 1
) (
    input  wire                  clk,
    input  wire                  rst_n,
    input  wire                  push,
    input  wire  [dataWidth-1:0] pushDat,
    input  wire                  flush,
    output logic                 full,
    input  wire                  pop,
    output logic [dataWidth-1:0] headDat,
    output logic                 empty
);

    localparam int depth = 1 << queueAddrWidth;

    typedef logic [queueAddrWidth-1:0] qPtr_t;
    typedef logic [queueAddrWidth:0]   qCnt_t;

    logic [dataWidth-1:0] mem [depth];
    qPtr_t wrPtr;
    qPtr_t rdPtr;
    qCnt_t cnt;
    logic  pushOk;
    logic  popOk;

    // A flush frees room for the push in the same cycle
    assign full    = (cnt == qCnt_t'(depth)) && !flush;
    assign empty   = (cnt == '0);
    assign headDat = mem[rdPtr];
    assign pushOk  = push && !full;
    assign popOk   = pop && !empty;

    // ========================================
    // Pointers and count
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrPtr <= '0;
            rdPtr <= '0;
            cnt   <= '0;
        end else if (flush) begin
            // Only the incoming entry survives
            rdPtr <= '0;
            wrPtr <= pushOk ? qPtr_t'(1) : '0;
            cnt   <= pushOk ? qCnt_t'(1) : '0;
        end else begin
            if (pushOk) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (popOk) begin
                rdPtr <= rdPtr + 1'b1;
            end
            cnt <= cnt + qCnt_t'(pushOk) - qCnt_t'(popOk);
        end
    end

    always_ff @(posedge clk) begin
        if (pushOk) begin
            mem[flush ? '0 : wrPtr] <= pushDat;
        end
    end

endmodule

`default_nettype wire

// ==== source/cfgIssuer.sv ====
// Engine configuration issuer
`timescale 1ns/1ps
`default_nettype none

module cfgIssuer
    import cfgPkg::*;
#(
    parameter int wordsPerIsa = 1
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire  [wordsPerIsa*wordWidth-1:0] headDat,
    input  wire                              empty,
    output logic                             pop,
    output logic [wordsPerIsa*wordWidth-1:0] cfgInfo,
    output logic                             cfgVld,
    input  wire                              cfgRdy
);

    logic load;

    // Take the next head when the register is free or leaving now
    assign load = !empty && (!cfgVld || cfgRdy);
    assign pop  = load;

    // ========================================
    // Output register
    // ========================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfgVld <= 1'b0;
        end else if (load) begin
            cfgVld <= 1'b1;
        end else if (cfgRdy) begin
            cfgVld <= 1'b0;
        end
    end

    // Held until the engine accepts
    always_ff @(posedge clk) begin
        if (load) begin
            cfgInfo <= headDat;
        end
    end

endmodule

`default_nettype wire

// ==== source/cfgDispatchTop.sv ====
// Configuration dispatch top level
`timescale 1ns/1ps
`default_nettype none

module cfgDispatchTop
    import cfgPkg::*;
#(
    parameter int queueAddrWidth = 1
) (
    input  wire                            clk,
    input  wire                            rst_n,
    input  wire isaWord_t                  inDat,
    input  wire                            inVld,
    input  wire                            inLast,
    output logic                           inRdy,
    output logic                           fpsCfgVld,
    input  wire                            fpsCfgRdy,
    output logic [fpsWords*wordWidth-1:0]  fpsCfgInfo,
    output logic                           syaCfgVld,
    input  wire                            syaCfgRdy,
    output logic [syaWords*wordWidth-1:0]  syaCfgInfo,
    output logic                           polCfgVld,
    input  wire                            polCfgRdy,
    output logic [polWords*wordWidth-1:0]  polCfgInfo
);

    logic [numEngines-1:0] wordVld;
    logic [numEngines-1:0] wordRdy;
    logic [numEngines-1:0] isaDone;
    logic [numEngines-1:0] cfgVldVec;
    logic [numEngines-1:0] cfgRdyVec;

    assign cfgRdyVec = {polCfgRdy, syaCfgRdy, fpsCfgRdy};
    assign {polCfgVld, syaCfgVld, fpsCfgVld} = cfgVldVec;

    isaDecoder u_decoder (
        .clk     (clk),
        .rst_n   (rst_n),
        .inDat   (inDat),
        .inVld   (inVld),
        .inLast  (inLast),
        .inRdy   (inRdy),
        .wordVld (wordVld),
        .wordRdy (wordRdy),
        .isaDone (isaDone)
    );

    // ========================================
    // Per-engine collect, queue and issue
    // ========================================
    for (genvar e = 0; e < numEngines; e++) begin : gEngine
        localparam int words = (e == 0) ? fpsWords : (e == 1) ? syaWords : polWords;

        logic [words*wordWidth-1:0] isaDat;
        logic [words*wordWidth-1:0] headDat;
        logic [words*wordWidth-1:0] cfgInfo;
        logic isaVld;
        logic isaRdy;
        logic qFull;
        logic qEmpty;
        logic pop;
        logic flush;

        assign isaRdy     = !qFull;
        assign isaDone[e] = isaVld && isaRdy;
        // Urgent instruction clears older entries
        assign flush      = isaVld && isaDat[urgentBit];

        isaCollector #(.wordsPerIsa(words)) u_collector (
            .clk (clk), .rst_n (rst_n),
            .wordDat (inDat), .wordVld (wordVld[e]), .wordRdy (wordRdy[e]),
            .isaDat (isaDat), .isaVld (isaVld), .isaRdy (isaRdy)
        );

        isaQueue #(.dataWidth(words*wordWidth), .queueAddrWidth(queueAddrWidth)) u_queue (
            .clk (clk), .rst_n (rst_n),
            .push (isaVld), .pushDat (isaDat), .flush (flush), .full (qFull),
            .pop (pop), .headDat (headDat), .empty (qEmpty)
        );

        cfgIssuer #(.wordsPerIsa(words)) u_issuer (
            .clk (clk), .rst_n (rst_n),
            .headDat (headDat), .empty (qEmpty), .pop (pop),
            .cfgInfo (cfgInfo), .cfgVld (cfgVldVec[e]), .cfgRdy (cfgRdyVec[e])
        );

        if (e == 0) begin : gFps
            assign fpsCfgInfo = cfgInfo;
        end else if (e == 1) begin : gSya
            assign syaCfgInfo = cfgInfo;
        end else begin : gPol
            assign polCfgInfo = cfgInfo;
        end
    end

endmodule

`default_nettype wire

// ==== dv/tbCfgDispatch.sv ====
// Dispatch unit testbench
`timescale 1ns/1ps
`default_nettype none

module tbCfgDispatch
    import cfgPkg::*;
();

    localparam int infoWidth    = polWords * wordWidth;
    localparam int numIsa       = 300;
    localparam int stepTimeout  = 200;
    localparam int drainTimeout = 400;

    typedef logic [infoWidth-1:0] cfgInfo_t;
    // Engine index sits above the packed instruction
    typedef logic [infoWidth+1:0] expEntry_t;

    logic                          clk;
    logic                          rst_n;
    isaWord_t                      inDat;
    logic                          inVld;
    logic                          inLast;
    logic                          inRdy;
    logic                          fpsCfgVld;
    logic                          fpsCfgRdy;
    logic [fpsWords*wordWidth-1:0] fpsCfgInfo;
    logic                          syaCfgVld;
    logic                          syaCfgRdy;
    logic [syaWords*wordWidth-1:0] syaCfgInfo;
    logic                          polCfgVld;
    logic                          polCfgRdy;
    logic [polWords*wordWidth-1:0] polCfgInfo;

    integer                seed;
    expEntry_t             expList[$];
    logic [numEngines-1:0] heldVld;
    cfgInfo_t              heldInfo [numEngines];
    logic                  inXfer;

    always #4 clk = ~clk;

    cfgDispatchTop u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .inDat      (inDat),
        .inVld      (inVld),
        .inLast     (inLast),
        .inRdy      (inRdy),
        .fpsCfgVld  (fpsCfgVld),
        .fpsCfgRdy  (fpsCfgRdy),
        .fpsCfgInfo (fpsCfgInfo),
        .syaCfgVld  (syaCfgVld),
        .syaCfgRdy  (syaCfgRdy),
        .syaCfgInfo (syaCfgInfo),
        .polCfgVld  (polCfgVld),
        .polCfgRdy  (polCfgRdy),
        .polCfgInfo (polCfgInfo)
    );

    task automatic abortRun(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    function automatic cfgInfo_t engineInfo(input int e);
        case (e)
            0:       return cfgInfo_t'(fpsCfgInfo);
            1:       return cfgInfo_t'(syaCfgInfo);
            default: return cfgInfo_t'(polCfgInfo);
        endcase
    endfunction

    // Only one urgent instruction per engine may be outstanding
    function automatic logic hasUrgent(input engineSel_t eng);
        logic hit;
        hit = 1'b0;
        foreach (expList[i]) begin
            if (expList[i][infoWidth +: 2] == eng && expList[i][urgentBit]) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    // ========================================
    // Compare tasks
    // ========================================
    task automatic checkIdle(input logic rdy, input logic [numEngines-1:0] vld);
        if (rdy !== 1'b0 || vld !== '0) begin
            abortRun($sformatf("[FAIL] %0t: after reset inRdy=%b cfgVld=%b, expected all low",
                               $time, rdy, vld));
        end
    endtask

    task automatic checkStable(input engineSel_t eng, input logic vld, input cfgInfo_t info);
        if (heldVld[eng] && (vld !== 1'b1 || info !== heldInfo[eng])) begin
            abortRun($sformatf("[FAIL] %0t: engine %0d changed cfgVld=%b cfgInfo=%h before accept",
                               $time, eng, vld, info));
        end
    endtask

    // Issued entry must be the oldest one, or an urgent one past flushed entries
    task automatic checkInfo(input engineSel_t eng, input cfgInfo_t obs);
        expEntry_t keep[$];
        int        found;
        int        skipped;
        logic      skippedUrgent;
        found         = -1;
        skipped       = 0;
        skippedUrgent = 1'b0;
        foreach (expList[i]) begin
            if (found < 0 && expList[i][infoWidth +: 2] == eng) begin
                if (expList[i][infoWidth-1:0] == obs) begin
                    found = i;
                end else begin
                    skipped++;
                    skippedUrgent = skippedUrgent | expList[i][urgentBit];
                end
            end
        end
        if (found < 0) begin
            abortRun($sformatf("[FAIL] %0t: engine %0d issued unexpected cfgInfo %h",
                               $time, eng, obs));
        end else if (skippedUrgent || (skipped > 0 && !obs[urgentBit])) begin
            abortRun($sformatf("[FAIL] %0t: engine %0d issued %h but dropped %0d older entries",
                               $time, eng, obs, skipped));
        end
        foreach (expList[i]) begin
            if (i > found || expList[i][infoWidth +: 2] != eng) begin
                keep.push_back(expList[i]);
            end
        end
        expList = keep;
    endtask

    // ========================================
    // Per-cycle drive and sample
    // ========================================
    task automatic driveReady(input logic allReady);
        fpsCfgRdy = allReady || ({$random(seed)} % 4 != 0);
        syaCfgRdy = allReady || ({$random(seed)} % 4 != 0);
        polCfgRdy = allReady || ({$random(seed)} % 4 != 0);
    endtask

    // Sample in the low phase, before the rising edge
    task automatic sampleCycle();
        logic [numEngines-1:0] vld;
        logic [numEngines-1:0] rdy;
        cfgInfo_t              info;
        #2;
        vld = {polCfgVld, syaCfgVld, fpsCfgVld};
        rdy = {polCfgRdy, syaCfgRdy, fpsCfgRdy};
        for (int e = 0; e < numEngines; e++) begin
            info = engineInfo(e);
            checkStable(engineSel_t'(e), vld[e], info);
            if (vld[e] && rdy[e]) begin
                checkInfo(engineSel_t'(e), info);
            end
            heldVld[e]  = vld[e] && !rdy[e];
            heldInfo[e] = info;
        end
        inXfer = inVld && inRdy;
    endtask

    task automatic sendIsa(input int idx);
        isaWord_t words [polWords];
        opcode_t  op;
        int       len;
        int       gap;
        int       waitCnt;
        logic     urgent;
        cfgInfo_t isaBits;
        // Opcode 5 has no engine and is discarded
        op = ({$random(seed)} % 8 == 0) ? opcode_t'(5) : opcode_t'({$random(seed)} % numEngines);
        len = (op == 0) ? fpsWords : (op == 1) ? syaWords : (op == 2) ? polWords :
              1 + int'({$random(seed)} % 3);
        urgent = (op < numEngines) && ({$random(seed)} % 8 == 0) && !hasUrgent(engineSel_t'(op));
        isaBits = '0;
        for (int w = 0; w < len; w++) begin
            words[w] = (w == 0) ? {idx[22:0], urgent, op} : isaWord_t'($random(seed));
            // Discarded payload looks like a valid first word
            if (w > 0 && op >= numEngines) begin
                words[w][opcodeWidth-1:0] = opcode_t'({$random(seed)} % numEngines);
            end
            isaBits[w*wordWidth +: wordWidth] = words[w];
        end
        for (int w = 0; w < len; w++) begin
            gap = ({$random(seed)} % 4 == 0) ? 1 + int'({$random(seed)} % 3) : 0;
            inVld  = 1'b0;
            inLast = 1'b0;
            repeat (gap) begin
                driveReady(1'b0);
                sampleCycle();
                @(negedge clk);
            end
            inDat   = words[w];
            inVld   = 1'b1;
            inLast  = (w == len - 1);
            inXfer  = 1'b0;
            waitCnt = 0;
            while (!inXfer) begin
                if (waitCnt == stepTimeout) begin
                    abortRun("Timed out waiting for the DUT to accept an input word");
                end
                driveReady(1'b0);
                sampleCycle();
                if (inXfer && inLast && op < numEngines) begin
                    expList.push_back({engineSel_t'(op), isaBits});
                end
                waitCnt++;
                @(negedge clk);
            end
        end
        inVld  = 1'b0;
        inLast = 1'b0;
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int   drainCnt;
        logic drained;
        seed      = 54;
        clk       = 1'b0;
        rst_n     = 1'b0;
        inDat     = '0;
        inVld     = 1'b0;
        inLast    = 1'b0;
        fpsCfgRdy = 1'b0;
        syaCfgRdy = 1'b0;
        polCfgRdy = 1'b0;
        heldVld   = '0;
        inXfer    = 1'b0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        #2;
        checkIdle(inRdy, {polCfgVld, syaCfgVld, fpsCfgVld});
        @(negedge clk);

        for (int i = 0; i < numIsa; i++) begin
            sendIsa(i);
        end

        // Open all engines once the stream is done and let the queues empty
        drainCnt = 0;
        drained  = 1'b0;
        while (!drained) begin
            if (drainCnt == drainTimeout) begin
                abortRun("Timed out: expected instructions were never issued after the stream");
            end
            driveReady(1'b1);
            sampleCycle();
            drained = (expList.size() == 0) && ({polCfgVld, syaCfgVld, fpsCfgVld} == '0);
            drainCnt++;
            @(negedge clk);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== cfgDispatch.f ====
source/cfgPkg.sv
source/isaDecoder.sv
source/isaCollector.sv
source/isaQueue.sv
source/cfgIssuer.sv
source/cfgDispatchTop.sv
dv/tbCfgDispatch.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the cfgDispatch testbench with Verilator

set -u
cd "$(dirname "$0")"

LOG=sim.log

if ! verilator --binary --timing -Wno-fatal --Mdir obj_dir \
        --top-module tbCfgDispatch -o VtbCfgDispatch -f cfgDispatch.f; then
    echo "Build failed"
    exit 1
fi

./obj_dir/VtbCfgDispatch > "$LOG" 2>&1
simStatus=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
    echo "Simulation failed"
    exit 1
fi

if [ "$simStatus" -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

echo "Simulation passed"
exit 0
